// File: all.f
+incdir+source
source/axil_mem_pkg.sv
source/mem_port_if.sv
source/axil_addr_check.sv
source/sram_bank.sv
source/axil_ctrl.sv
source/axil_inst_mem.sv
testbench/axil_ctrl_assertions.sv
testbench/tb_axil_inst_mem.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; the result is read from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_inst_mem -f all.f -o tb_axil_inst_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_axil_inst_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: source/axil_addr_check.sv
// Purely combinational; only full 8-byte aligned words inside the decoded window get OKAY
`timescale 1ns/1ps
`include "axil_mem_defs.svh"

module axil_addr_check (
  input  axil_mem_pkg::addr_t     i_addr,
  output axil_mem_pkg::word_idx_t o_idx,
  output axil_mem_pkg::resp_t     o_resp
);

  localparam int OFFS_W = $clog2(`AXIL_STRB_W);
  localparam axil_mem_pkg::addr_t MEM_BYTES = `AXIL_ADDR_W'(`AXIL_MEM_DEPTH * `AXIL_STRB_W);

  axil_mem_pkg::addr_t offset;
  logic                aligned;
  logic                in_range;

  // Addresses below the base wrap to large offsets and fail the range test
  assign offset   = i_addr - axil_mem_pkg::addr_t'(`AXIL_MEM_BASE);
  assign aligned  = (offset[OFFS_W-1:0] == '0);
  assign in_range = (offset < MEM_BYTES);

  assign o_idx = offset[OFFS_W +: $bits(axil_mem_pkg::word_idx_t)];

  always_comb begin
    if (aligned && in_range) begin
      o_resp = axil_mem_pkg::RESP_OKAY;
    end else begin
      o_resp = axil_mem_pkg::RESP_SLVERR;
    end
  end

endmodule

// File: source/axil_ctrl.sv
// One AXI-lite transaction at a time; write and read requests alternate when both wait in IDLE
`timescale 1ns/1ps
`include "axil_mem_defs.svh"

module axil_ctrl (
  input  logic                    i_aclk,
  input  logic                    rst,

  // Write address and data
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  axil_mem_pkg::data_t     i_wdata,
  input  axil_mem_pkg::strb_t     i_wstrb,
  input  axil_mem_pkg::word_idx_t i_aw_idx,
  input  axil_mem_pkg::resp_t     i_aw_resp,

  // Write response
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output axil_mem_pkg::resp_t     o_bresp,

  // Read address
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  axil_mem_pkg::word_idx_t i_ar_idx,
  input  axil_mem_pkg::resp_t     i_ar_resp,

  // Read data
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output axil_mem_pkg::data_t     o_rdata,
  output axil_mem_pkg::resp_t     o_rresp,

  mem_port_if.ctrl                mem
);

  axil_mem_pkg::ctrl_state_t state;
  axil_mem_pkg::ctrl_state_t state_next;

  logic                wr_req;
  logic                rd_req;
  logic                prefer_rd;
  axil_mem_pkg::resp_t bresp_q;
  axil_mem_pkg::resp_t rresp_q;

  assign wr_req = i_awvalid && i_wvalid;
  assign rd_req = i_arvalid;

  always_comb begin
    state_next = state;
    case (state)
      axil_mem_pkg::IDLE: begin
        // Write wins unless a read is also waiting and it is the read's turn
        if (wr_req && !(rd_req && prefer_rd)) begin
          state_next = axil_mem_pkg::W_ACCEPT;
        end else if (rd_req) begin
          state_next = axil_mem_pkg::R_ACCEPT;
        end
      end
      axil_mem_pkg::W_ACCEPT: state_next = axil_mem_pkg::B_WAIT;
      axil_mem_pkg::B_WAIT:   if (i_bready) state_next = axil_mem_pkg::IDLE;
      axil_mem_pkg::R_ACCEPT: state_next = axil_mem_pkg::R_WAIT;
      axil_mem_pkg::R_WAIT:   if (i_rready) state_next = axil_mem_pkg::IDLE;
      default:                state_next = axil_mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (rst) begin
      state     <= axil_mem_pkg::IDLE;
      prefer_rd <= 1'b0;
    end else begin
      state <= state_next;
      // Turn passes to the other kind once a request is taken
      if (state == axil_mem_pkg::IDLE && state_next == axil_mem_pkg::W_ACCEPT) begin
        prefer_rd <= 1'b1;
      end else if (state == axil_mem_pkg::IDLE && state_next == axil_mem_pkg::R_ACCEPT) begin
        prefer_rd <= 1'b0;
      end
    end
  end

  // Response codes captured in the transfer cycle
  always_ff @(posedge i_aclk) begin
    if (state == axil_mem_pkg::W_ACCEPT) begin
      bresp_q <= i_aw_resp;
    end
    if (state == axil_mem_pkg::R_ACCEPT) begin
      rresp_q <= i_ar_resp;
    end
  end

  // Channel handshakes decoded from state
  assign o_awready = (state == axil_mem_pkg::W_ACCEPT);
  assign o_wready  = (state == axil_mem_pkg::W_ACCEPT);
  assign o_arready = (state == axil_mem_pkg::R_ACCEPT);
  assign o_bvalid  = (state == axil_mem_pkg::B_WAIT);
  assign o_rvalid  = (state == axil_mem_pkg::R_WAIT);
  assign o_bresp   = bresp_q;
  assign o_rresp   = rresp_q;

  // Error reads never enable the bank, so the stale word is masked
  assign o_rdata = (rresp_q == axil_mem_pkg::RESP_OKAY) ? mem.rdata : '0;

  // Bank access only for OKAY accesses during the transfer cycle
  assign mem.en    = (o_awready && i_aw_resp == axil_mem_pkg::RESP_OKAY) ||
                     (o_arready && i_ar_resp == axil_mem_pkg::RESP_OKAY);
  assign mem.we    = o_awready;
  assign mem.idx   = o_awready ? i_aw_idx : i_ar_idx;
  assign mem.wdata = i_wdata;
  assign mem.wstrb = i_wstrb;

endmodule

// File: source/axil_inst_mem.sv
// AXI-lite slave instruction memory; no bursts, no protection signals, single outstanding access
`timescale 1ns/1ps
`include "axil_mem_defs.svh"

module axil_inst_mem (
  input  logic                i_aclk,
  input  logic                rst,

  input  logic                i_awvalid,
  output logic                o_awready,
  input  axil_mem_pkg::addr_t i_awaddr,

  input  logic                i_wvalid,
  output logic                o_wready,
  input  axil_mem_pkg::data_t i_wdata,
  input  axil_mem_pkg::strb_t i_wstrb,

  output logic                o_bvalid,
  input  logic                i_bready,
  output axil_mem_pkg::resp_t o_bresp,

  input  logic                i_arvalid,
  output logic                o_arready,
  input  axil_mem_pkg::addr_t i_araddr,

  output logic                o_rvalid,
  input  logic                i_rready,
  output axil_mem_pkg::data_t o_rdata,
  output axil_mem_pkg::resp_t o_rresp
);

  axil_mem_pkg::word_idx_t aw_idx;
  axil_mem_pkg::resp_t     aw_resp;
  axil_mem_pkg::word_idx_t ar_idx;
  axil_mem_pkg::resp_t     ar_resp;

  mem_port_if mem_port ();

  // Address decode for each channel
  axil_addr_check aw_check_i (
    .i_addr (i_awaddr),
    .o_idx  (aw_idx),
    .o_resp (aw_resp)
  );

  axil_addr_check ar_check_i (
    .i_addr (i_araddr),
    .o_idx  (ar_idx),
    .o_resp (ar_resp)
  );

  axil_ctrl ctrl_i (
    .i_aclk    (i_aclk),
    .rst       (rst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_aw_idx  (aw_idx),
    .i_aw_resp (aw_resp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_ar_idx  (ar_idx),
    .i_ar_resp (ar_resp),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .mem       (mem_port.ctrl)
  );

  sram_bank bank_i (
    .i_aclk (i_aclk),
    .port   (mem_port.bank)
  );

endmodule

// File: source/axil_mem_defs.svh
// Sizes for the instruction memory; data width must be a multiple of 8 and depth a power of two
`ifndef AXIL_MEM_DEFS_SVH
`define AXIL_MEM_DEFS_SVH

// AXI-lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 64
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Number of data words in the bank
`define AXIL_MEM_DEPTH 256

// First byte address decoded by the slave
`define AXIL_MEM_BASE 32'h8000_0000

`endif

// File: source/axil_mem_pkg.sv
// Types for the AXI-lite instruction memory; widths follow the macros in axil_mem_defs.svh
`include "axil_mem_defs.svh"

package axil_mem_pkg;

  // Bus payloads
  typedef logic [`AXIL_ADDR_W-1:0] addr_t;
  typedef logic [`AXIL_DATA_W-1:0] data_t;
  typedef logic [`AXIL_STRB_W-1:0] strb_t;

  // Word index into the bank
  typedef logic [$clog2(`AXIL_MEM_DEPTH)-1:0] word_idx_t;

  // AXI response codes, only OKAY and SLVERR are produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  // Control FSM states
  typedef enum logic [2:0] {
    IDLE,
    W_ACCEPT,
    B_WAIT,
    R_ACCEPT,
    R_WAIT
  } ctrl_state_t;

endpackage

// File: source/mem_port_if.sv
// Single-port SRAM access; the bank acts on en at the next edge and rdata holds until the next read
`timescale 1ns/1ps
`include "axil_mem_defs.svh"

interface mem_port_if;

  logic                  en;
  logic                  we;
  axil_mem_pkg::word_idx_t idx;
  axil_mem_pkg::data_t   wdata;
  axil_mem_pkg::strb_t   wstrb;
  axil_mem_pkg::data_t   rdata;

  // Controller side
  modport ctrl (
    output en, we, idx, wdata, wstrb,
    input  rdata
  );

  // Memory side
  modport bank (
    input  en, we, idx, wdata, wstrb,
    output rdata
  );

endinterface

// File: source/sram_bank.sv
// Synchronous single-port word memory without reset; contents are undefined until written
`timescale 1ns/1ps
`include "axil_mem_defs.svh"

module sram_bank (
  input  logic          i_aclk,
  mem_port_if.bank      port
);

  axil_mem_pkg::data_t mem [`AXIL_MEM_DEPTH];

  // Byte lanes enabled by wstrb are written, the rest keep their value
  always_ff @(posedge i_aclk) begin
    if (port.en && port.we) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (port.wstrb[b]) begin
          mem[port.idx][8*b +: 8] <= port.wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered read port, output holds between reads
  always_ff @(posedge i_aclk) begin
    if (port.en && !port.we) begin
      port.rdata <= mem[port.idx];
    end
  end

endmodule

// File: testbench/axil_ctrl_assertions.sv
// Handshake rules of the AXI-lite control FSM; all properties are off while rst is high
`timescale 1ns/1ps

module axil_ctrl_assertions (
  input logic                i_aclk,
  input logic                rst,
  input logic                o_awready,
  input logic                o_wready,
  input logic                o_arready,
  input logic                o_bvalid,
  input logic                i_bready,
  input axil_mem_pkg::resp_t o_bresp,
  input logic                o_rvalid,
  input logic                i_rready,
  input axil_mem_pkg::data_t o_rdata,
  input axil_mem_pkg::resp_t o_rresp
);

  // Readies are single-cycle pulses
  ready_pulse: assert property (@(posedge i_aclk) disable iff (rst)
    (o_awready || o_wready || o_arready) |=> !(o_awready || o_wready || o_arready))
    else $error("ready stayed high for more than one cycle");

  b_hold: assert property (@(posedge i_aclk) disable iff (rst)
    (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp)))
    else $error("write response dropped or changed before bready");

  r_hold: assert property (@(posedge i_aclk) disable iff (rst)
    (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rresp)))
    else $error("read response dropped or changed before rready");

  one_resp: assert property (@(posedge i_aclk) disable iff (rst)
    !(o_bvalid && o_rvalid))
    else $error("bvalid and rvalid high in the same cycle");

endmodule

bind axil_ctrl axil_ctrl_assertions assertions_i (.*);

// File: testbench/tb_axil_inst_mem.sv
// Read data is checked only on words written earlier in the run, the bank has no reset
`timescale 1ns/1ps
`include "axil_mem_defs.svh"

module tb_axil_inst_mem;

  localparam int unsigned WORD_BYTES = `AXIL_STRB_W;
  localparam int unsigned MEM_BYTES  = `AXIL_MEM_DEPTH * `AXIL_STRB_W;
  localparam int          MAX_CYCLES = 20000;

  logic                i_aclk;
  logic                rst;
  logic                i_awvalid;
  logic                o_awready;
  axil_mem_pkg::addr_t i_awaddr;
  logic                i_wvalid;
  logic                o_wready;
  axil_mem_pkg::data_t i_wdata;
  axil_mem_pkg::strb_t i_wstrb;
  logic                o_bvalid;
  logic                i_bready;
  axil_mem_pkg::resp_t o_bresp;
  logic                i_arvalid;
  logic                o_arready;
  axil_mem_pkg::addr_t i_araddr;
  logic                o_rvalid;
  logic                i_rready;
  axil_mem_pkg::data_t o_rdata;
  axil_mem_pkg::resp_t o_rresp;

  // Reference memory and expected responses in acceptance order
  axil_mem_pkg::data_t model_mem [`AXIL_MEM_DEPTH];
  axil_mem_pkg::resp_t bresp_q [$];
  axil_mem_pkg::data_t rdata_q [$];
  axil_mem_pkg::resp_t rresp_q [$];
  bit                  served_q [$];
  int                  written_q [$];
  bit                  pending = 1'b0;
  int                  checks = 0;
  int                  errors = 0;
  int                  cycles = 0;

  axil_inst_mem dut_i (.*);

  initial begin
    i_aclk = 1'b0;
    forever #4 i_aclk = ~i_aclk;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge i_aclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("FAIL %0t: %s", $time, msg);
    end
  endtask

  // Expected response and data from the address window and the strobe merge
  function automatic void model_access(
    input  bit                  is_write,
    input  axil_mem_pkg::addr_t addr,
    input  axil_mem_pkg::data_t wdata,
    input  axil_mem_pkg::strb_t wstrb,
    output axil_mem_pkg::data_t exp_data,
    output axil_mem_pkg::resp_t exp_resp
  );
    axil_mem_pkg::addr_t offset;
    bit                  ok;
    int                  idx;
    offset   = addr - axil_mem_pkg::addr_t'(`AXIL_MEM_BASE);
    ok       = (addr >= `AXIL_MEM_BASE) && (offset < MEM_BYTES) && (offset % WORD_BYTES == 0);
    exp_data = '0;
    exp_resp = ok ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
    if (ok) begin
      idx = int'(offset / WORD_BYTES);
      if (is_write) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
          if (wstrb[b]) begin
            model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end
      exp_data = model_mem[idx];
    end
  endfunction

  function automatic axil_mem_pkg::addr_t word_addr(input int idx);
    return axil_mem_pkg::addr_t'(`AXIL_MEM_BASE) + axil_mem_pkg::addr_t'(idx * WORD_BYTES);
  endfunction

  task automatic apply_reset();
    rst       = 1'b1;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_araddr  = '0;
    i_rready  = 1'b0;
    repeat (4) @(posedge i_aclk);
    #1;
    rst = 1'b0;
  endtask

  // One complete access that starts and ends 1 ns after a rising edge
  task automatic run_access(
    input bit                  wr,
    input axil_mem_pkg::addr_t addr,
    input axil_mem_pkg::data_t data,
    input axil_mem_pkg::strb_t strb,
    input int                  max_dly
  );
    int dly;
    dly = $urandom_range(max_dly, 0);
    if (wr) begin
      i_awaddr  = addr;
      i_wdata   = data;
      i_wstrb   = strb;
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
    end else begin
      i_araddr  = addr;
      i_arvalid = 1'b1;
    end
    // Ready seen now means the transfer happens at the next edge
    do begin
      @(posedge i_aclk);
      #1;
    end while (wr ? !o_awready : !o_arready);
    @(posedge i_aclk);
    #1;
    if (wr) begin
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
    end else begin
      i_arvalid = 1'b0;
    end
    while (wr ? !o_bvalid : !o_rvalid) begin
      @(posedge i_aclk);
      #1;
    end
    // Stall the response for a few cycles
    repeat (dly) begin
      @(posedge i_aclk);
      #1;
    end
    if (wr) begin
      i_bready = 1'b1;
    end else begin
      i_rready = 1'b1;
    end
    @(posedge i_aclk);
    #1;
    i_bready = 1'b0;
    i_rready = 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    $display("Test %0d %s: %0d errors", num, name, errors - err_before);
  endtask

  // Compare process samples mid-cycle where all signals are settled
  always @(negedge i_aclk) begin
    axil_mem_pkg::data_t exp_data;
    axil_mem_pkg::resp_t exp_resp;
    if (rst) begin
      pending = 1'b0;
    end else begin
      if (i_awvalid && i_wvalid && o_awready && o_wready) begin
        check_true(!pending, "write accepted before the previous response transferred");
        model_access(1'b1, i_awaddr, i_wdata, i_wstrb, exp_data, exp_resp);
        bresp_q.push_back(exp_resp);
        served_q.push_back(1'b1);
        pending = 1'b1;
      end
      if (i_arvalid && o_arready) begin
        check_true(!pending, "read accepted before the previous response transferred");
        model_access(1'b0, i_araddr, '0, '0, exp_data, exp_resp);
        rdata_q.push_back(exp_data);
        rresp_q.push_back(exp_resp);
        served_q.push_back(1'b0);
        pending = 1'b1;
      end
      if (o_bvalid && i_bready) begin
        if (bresp_q.size() == 0) begin
          check_true(1'b0, "write response without an accepted write");
        end else begin
          exp_resp = bresp_q.pop_front();
          check_true(o_bresp == exp_resp,
                     $sformatf("bresp %0d, expected %0d", o_bresp, exp_resp));
        end
        pending = 1'b0;
      end
      if (o_rvalid && i_rready) begin
        if (rdata_q.size() == 0) begin
          check_true(1'b0, "read data without an accepted read");
        end else begin
          exp_data = rdata_q.pop_front();
          exp_resp = rresp_q.pop_front();
          check_true(o_rdata === exp_data && o_rresp == exp_resp,
                     $sformatf("read %h resp %0d, expected %h resp %0d",
                               o_rdata, o_rresp, exp_data, exp_resp));
        end
        pending = 1'b0;
      end
    end
  end

  initial begin
    axil_mem_pkg::addr_t addr;
    int                  idx;
    int                  err0;
    void'($urandom(32'hed92_beea));
    apply_reset();

    err0 = errors;
    check_true(!(o_awready || o_wready || o_arready || o_bvalid || o_rvalid),
               "a valid or ready output is high after reset");
    repeat (32) begin
      idx = $urandom_range(`AXIL_MEM_DEPTH - 1, 0);
      written_q.push_back(idx);
      run_access(1'b1, word_addr(idx), {$urandom, $urandom}, '1, 0);
    end
    foreach (written_q[i]) begin
      run_access(1'b0, word_addr(written_q[i]), '0, '0, 0);
    end
    report_test(1, "full-word write and read back", err0);

    err0 = errors;
    repeat (32) begin
      idx = written_q[$urandom_range(written_q.size() - 1, 0)];
      run_access(1'b1, word_addr(idx), {$urandom, $urandom}, axil_mem_pkg::strb_t'($urandom), 0);
      run_access(1'b0, word_addr(idx), '0, '0, 0);
    end
    report_test(2, "partial strobe merge", err0);

    err0 = errors;
    repeat (16) begin
      idx = written_q[$urandom_range(written_q.size() - 1, 0)];
      case ($urandom_range(2, 0))
        0:       addr = word_addr(idx) + axil_mem_pkg::addr_t'($urandom_range(WORD_BYTES - 1, 1));
        1:       addr = word_addr(idx) + axil_mem_pkg::addr_t'(MEM_BYTES);
        default: addr = word_addr(idx) - axil_mem_pkg::addr_t'(MEM_BYTES);
      endcase
      run_access(1'b1, addr, {$urandom, $urandom}, '1, 0);
      run_access(1'b0, addr, '0, '0, 0);
      // Aliased word must be untouched
      run_access(1'b0, word_addr(idx), '0, '0, 0);
    end
    report_test(3, "misaligned and out-of-range errors", err0);

    err0 = errors;
    repeat (24) begin
      idx = written_q[$urandom_range(written_q.size() - 1, 0)];
      run_access(1'b1, word_addr(idx), {$urandom, $urandom}, axil_mem_pkg::strb_t'($urandom), 7);
      run_access(1'b0, word_addr(idx), '0, '0, 7);
    end
    report_test(4, "response back-pressure", err0);

    err0 = errors;
    repeat (8) begin
      idx = written_q[$urandom_range(written_q.size() - 1, 0)];
      apply_reset();
      served_q.delete();
      fork
        begin
          run_access(1'b1, word_addr(idx), {$urandom, $urandom}, '1, 3);
          run_access(1'b1, word_addr(idx), {$urandom, $urandom}, '1, 3);
        end
        run_access(1'b0, word_addr(idx), '0, '0, 3);
      join
      check_true(served_q.size() == 3 && served_q[0] && !served_q[1] && served_q[2],
                 "service order after reset was not write, read, write");
    end
    report_test(5, "write and read arbitration", err0);

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
